// ==== fpEstTable.f ====
+incdir+rtl
rtl/fpEstTable_pkg.sv
rtl/estIndexGen.sv
rtl/estTableRam.sv
rtl/estResultMerge.sv
rtl/fpEstTable.sv
dv/fpEstTable_props.sv
dv/fpEstTable_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f fpEstTable.f \
  --top-module fpEstTable_tb -o fpEstTable_sim > build.log 2>&1 \
  && ./obj_dir/fpEstTable_sim > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"

grep -q "^Everything OK$" sim.log 2>/dev/null && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }

// ==== dv/fpEstTable_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpEstTable_macros.svh"

module fpEstTable_tb;

  localparam int reps      = 4;    // Random mantissas per exponent.
  localparam int mixOps    = 200;
  localparam int numOps    = 2 + `FPE_TABLE_DEPTH + 8 * 9 * reps + mixOps + 30;
  localparam int timeoutNs = numOps * 8 * 2 + 1000;

  logic                  clk = 1'b0;
  logic                  arstN;
  fpEstTable_pkg::fpWord opA;
  fpEstTable_pkg::fpWord opB;
  fpEstTable_pkg::estOp  op;
  logic                  readEn;
  logic                  writeEn;
  fpEstTable_pkg::fpWord res;
  logic                  resValid;

  integer                seed = 47349;
  fpEstTable_pkg::fpWord shadow [512];  // Slots past the table stay zero.
  fpEstTable_pkg::fpWord expQ [$];
  logic [2:0]            opQ [$];
  int                    cycQ [$];
  int                    cyc = 0;

  always #4 clk = ~clk;

  fpEstTable u_dut (
    .clk      (clk),
    .arstN    (arstN),
    .opA      (opA),
    .opB      (opB),
    .op       (op),
    .readEn   (readEn),
    .writeEn  (writeEn),
    .res      (res),
    .resValid (resValid)
  );

  // ####################
  // Reference model.
  // ####################

  function automatic fpEstTable_pkg::fpWord randWord();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[67:0];
  endfunction

  function automatic fpEstTable_pkg::fpWord withExp(input int e);
    fpEstTable_pkg::fpWord w;
    w = randWord();
    w[65:54] = e[11:0];
    return w;
  endfunction

  // Bucket code from exponent distance and mantissa top bits.
  function automatic int bucketCode(input int opc, input int e, input int m5);
    int k;
    int code;
    k = e - ((opc <= 1) ? 2040 : 2044);
    code = 0;
    if (k >= 1 && k <= 6) begin
      if (opc == 1) begin
        code = (e % 2) * 32;
        if (k >= 2) code = code + 16 + (m5 >> (7 - k));
      end else begin
        code = 32 + (m5 >> (6 - k));
      end
    end
    return code;
  endfunction

  function automatic int slotFor(input int opc, input fpEstTable_pkg::fpWord a);
    int code;
    code = bucketCode(opc, int'(a[65:54]), int'(a[53:49]));
    return ((opc >= 4) ? 256 : opc % 4) + 4 * code;
  endfunction

  function automatic int maskOf(input int opc, input int e);
    int k;
    int m;
    k = e - ((opc == 7) ? 2044 : 2040);
    m = (k >= 1 && k <= 6) ? (1 << k) - 1 : 0;
    return (m << ((opc == 6) ? 2 : 1)) & 63;
  endfunction

  function automatic fpEstTable_pkg::fpWord expectOf(input int opc,
                                                     input fpEstTable_pkg::fpWord a);
    fpEstTable_pkg::fpWord w;
    int field;
    w = '0;
    if (opc <= 4) begin
      w = shadow[slotFor(opc, a)];
      if ((opc == 0 || opc == 2) && a[64]) w[64] = ~w[64];
    end else begin
      field = int'(a[52:47]) & maskOf(opc, int'(a[65:54]));
      w[52:47] = field[5:0];
    end
    return w;
  endfunction

  // ####################
  // Drivers.
  // ####################

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped on error");
  endtask

  task automatic issue(input logic rd, input int opc, input fpEstTable_pkg::fpWord a,
                       input logic wr, input int wAddr);
    fpEstTable_pkg::fpWord b;
    b = '0;
    b[53:45] = wAddr[8:0];
    @(posedge clk);
    readEn  <= rd;
    writeEn <= wr;
    op      <= fpEstTable_pkg::estOp'(opc[2:0]);
    opA     <= a;
    opB     <= b;
    if (wr && wAddr < `FPE_TABLE_DEPTH) shadow[wAddr] = a;  // Same-cycle reads see it.
    if (rd) begin
      expQ.push_back(expectOf(opc, a));
      opQ.push_back(opc[2:0]);
      cycQ.push_back(cyc);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      readEn  <= 1'b0;
      writeEn <= 1'b0;
    end
  endtask

  task automatic sweep(input int opc, input int eLo, input int eHi);
    for (int e = eLo; e <= eHi; e++) begin
      for (int r = 0; r < reps; r++) begin
        issue(1'b1, opc, withExp(e), 1'b0, 0);
      end
    end
  endtask

  // ####################
  // Scoreboard.
  // ####################

  always @(negedge clk) begin : resultCheck
    fpEstTable_pkg::fpWord expWord;
    logic [2:0]            expOp;
    int                    issued;
    cyc <= cyc + 1;
    if (resValid) begin
      assert (expQ.size() > 0)
        else abortRun($sformatf("resValid at %0t with no read outstanding", $time));
      expWord = expQ.pop_front();
      expOp   = opQ.pop_front();
      issued  = cycQ.pop_front();
      assert (cyc - issued == `FPE_LATENCY)
        else abortRun($sformatf("mismatch at %0t: op %0d result came after %0d cycles",
                                $time, expOp, cyc - issued));
      assert (res === expWord)
        else abortRun($sformatf("mismatch at %0t: op %0d gave %h, expected %h",
                                $time, expOp, res, expWord));
    end
  end

  initial begin : watchdog
    #(timeoutNs);
    abortRun($sformatf("timeout: run did not finish within %0d ns", timeoutNs));
  end

  // ####################
  // Stimulus.
  // ####################

  initial begin
    int                    opc;
    int                    e;
    int                    s;
    int                    prevSlot;
    fpEstTable_pkg::fpWord a;
    for (int i = 0; i < 512; i++) shadow[i] = '0;
    arstN   <= 1'b0;
    readEn  <= 1'b0;
    writeEn <= 1'b0;
    op      <= fpEstTable_pkg::opRecip;
    opA     <= '0;
    opB     <= '0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    assert (res === '0 && resValid === 1'b0)
      else abortRun($sformatf("mismatch at %0t: outputs not cleared by reset", $time));

    for (int i = 0; i < `FPE_TABLE_DEPTH; i++) issue(1'b0, 0, randWord(), 1'b1, i);
    idle(2);

    sweep(0, 2039, 2047);  // Seeds for the lower region.
    sweep(1, 2039, 2047);
    idle(2);
    for (opc = 2; opc <= 4; opc++) sweep(opc, 2043, 2051);
    idle(2);
    sweep(5, 2039, 2047);  // Masked fractions.
    sweep(6, 2039, 2047);
    sweep(7, 2043, 2051);
    idle(2);

    // Reads every cycle, each writing its own slot. A slot read in the previous
    // cycle is not written, since that read is still in flight.
    prevSlot = -1;
    for (int i = 0; i < mixOps; i++) begin
      opc = $unsigned($random(seed)) % 5;
      e   = 2039 + $unsigned($random(seed)) % 13;
      a   = withExp(e);
      s   = slotFor(opc, a);
      issue(1'b1, opc, a, s < `FPE_TABLE_DEPTH && s != prevSlot, s);
      prevSlot = s;
    end
    idle(1);

    while (expQ.size() != 0) begin
      @(posedge clk);
    end
    repeat (2 * `FPE_LATENCY) @(posedge clk);  // A stray strobe would show here.
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/fpEstTable_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpEstTable_macros.svh"

module fpEstTable_props (
  input wire logic                  clk,
  input wire logic                  arstN,
  input wire fpEstTable_pkg::fpWord opB,
  input wire logic                  readEn,
  input wire logic                  writeEn,
  input wire logic                  resValid
);

  // ####################
  // Reset and latency.
  // ####################

  resetQuiet: assert property (@(posedge clk) !arstN |-> !resValid)
    else $error("resValid high while reset is asserted");

  readGivesValid: assert property (@(posedge clk) disable iff (!arstN)
    $past(readEn, `FPE_LATENCY) |-> resValid)
    else $error("read not followed by resValid after %0d cycles", `FPE_LATENCY);

  // Every strobe traces back to one read.
  validHasRead: assert property (@(posedge clk) disable iff (!arstN)
    resValid |-> $past(readEn, `FPE_LATENCY))
    else $error("resValid without a read %0d cycles earlier", `FPE_LATENCY);

  // ####################
  // Write address.
  // ####################

  legalWrite: assert property (@(posedge clk) disable iff (!arstN)
    writeEn |-> opB[`FPE_WADDR_LSB +: `FPE_ADDR_W] < `FPE_TABLE_DEPTH)
    else $error("write to an address past the table");

endmodule

bind fpEstTable fpEstTable_props u_props (
  .clk      (clk),
  .arstN    (arstN),
  .opB      (opB),
  .readEn   (readEn),
  .writeEn  (writeEn),
  .resValid (resValid)
);

`default_nettype wire

// ==== rtl/fpEstTable.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpEstTable_macros.svh"

module fpEstTable (
  input  wire logic                  clk,
  input  wire logic                  arstN,
  input  wire fpEstTable_pkg::fpWord opA,
  input  wire fpEstTable_pkg::fpWord opB,
  input  wire fpEstTable_pkg::estOp  op,
  input  wire logic                  readEn,
  input  wire logic                  writeEn,
  output fpEstTable_pkg::fpWord      res,
  output logic                       resValid
);

  fpEstTable_pkg::tableIdx wrAddr;
  fpEstTable_pkg::tableIdx idxSlot;
  logic [5:0]              idxMask;
  logic [5:0]              idxField;
  logic                    idxTableOp;
  logic                    idxFlip;
  logic                    idxValid;

  fpEstTable_pkg::fpWord   ramData;
  logic [5:0]              ramMask;
  logic [5:0]              ramField;
  logic                    ramTableOp;
  logic                    ramFlip;
  logic                    ramValid;

  assign wrAddr = opB[`FPE_WADDR_LSB +: `FPE_ADDR_W];

  // ####################
  // Pipeline.
  // ####################

  estIndexGen u_indexGen (
    .clk       (clk),
    .arstN     (arstN),
    .opA       (opA),
    .op        (op),
    .readEn    (readEn),
    .slot      (idxSlot),
    .fracMask  (idxMask),
    .isTableOp (idxTableOp),
    .flipSign  (idxFlip),
    .fracField (idxField),
    .rdValid   (idxValid)
  );

  // Writes bypass the index stage.
  estTableRam u_tableRam (
    .clk         (clk),
    .arstN       (arstN),
    .writeEn     (writeEn),
    .wrAddr      (wrAddr),
    .wrData      (opA),
    .slot        (idxSlot),
    .isTableOpIn (idxTableOp),
    .flipSignIn  (idxFlip),
    .fracMaskIn  (idxMask),
    .fracFieldIn (idxField),
    .rdValidIn   (idxValid),
    .rdData      (ramData),
    .isTableOp   (ramTableOp),
    .flipSign    (ramFlip),
    .fracMask    (ramMask),
    .fracField   (ramField),
    .rdValid     (ramValid)
  );

  estResultMerge u_resultMerge (
    .clk       (clk),
    .arstN     (arstN),
    .rdData    (ramData),
    .isTableOp (ramTableOp),
    .flipSign  (ramFlip),
    .fracMask  (ramMask),
    .fracField (ramField),
    .rdValid   (ramValid),
    .res       (res),
    .resValid  (resValid)
  );

endmodule

`default_nettype wire

// ==== rtl/estResultMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

module estResultMerge (
  input  wire logic                  clk,
  input  wire logic                  arstN,
  input  wire fpEstTable_pkg::fpWord rdData,
  input  wire logic                  isTableOp,
  input  wire logic                  flipSign,
  input  wire logic [5:0]            fracMask,
  input  wire logic [5:0]            fracField,
  input  wire logic                  rdValid,
  output fpEstTable_pkg::fpWord      res,
  output logic                       resValid
);

  localparam int flipBit = 64;
  localparam int fracLsb = 47;  // Field lands at 52:47.

  fpEstTable_pkg::fpWord tableWord;
  fpEstTable_pkg::fpWord fracWord;
  fpEstTable_pkg::fpWord nextRes;

  // ####################
  // Select.
  // ####################

  always_comb begin
    tableWord          = rdData;
    tableWord[flipBit] = rdData[flipBit] ^ flipSign;

    fracWord                = '0;  // Everything outside the field is zero.
    fracWord[fracLsb +: 6] = fracField & fracMask;

    nextRes = isTableOp ? tableWord : fracWord;
  end

  // ####################
  // Output register.
  // ####################

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      res      <= '0;
      resValid <= 1'b0;
    end else begin
      resValid <= rdValid;
      if (rdValid) begin
        res <= nextRes;  // Holds between reads.
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/estTableRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpEstTable_macros.svh"

module estTableRam (
  input  wire logic                    clk,
  input  wire logic                    arstN,
  input  wire logic                    writeEn,
  input  wire fpEstTable_pkg::tableIdx wrAddr,
  input  wire fpEstTable_pkg::fpWord   wrData,
  input  wire fpEstTable_pkg::tableIdx slot,
  input  wire logic                    isTableOpIn,
  input  wire logic                    flipSignIn,
  input  wire logic [5:0]              fracMaskIn,
  input  wire logic [5:0]              fracFieldIn,
  input  wire logic                    rdValidIn,
  output fpEstTable_pkg::fpWord        rdData,
  output logic                         isTableOp,
  output logic                         flipSign,
  output logic [5:0]                   fracMask,
  output logic [5:0]                   fracField,
  output logic                         rdValid
);

  localparam fpEstTable_pkg::tableIdx lastSlot =
    fpEstTable_pkg::tableIdx'(`FPE_TABLE_DEPTH - 1);

  fpEstTable_pkg::fpWord mem [`FPE_TABLE_DEPTH];
  fpEstTable_pkg::fpWord rdWord;
  logic                  wrInRange;
  logic                  rdInRange;

  assign wrInRange = wrAddr <= lastSlot;
  assign rdInRange = slot <= lastSlot;

  // ####################
  // Storage.
  // ####################

  always_ff @(posedge clk) begin
    if (writeEn && wrInRange) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Write-first on a same-cycle hit. Slots past the table read as zero.
  always_comb begin
    if (!rdInRange) begin
      rdWord = '0;
    end else if (writeEn && wrAddr == slot) begin
      rdWord = wrData;
    end else begin
      rdWord = mem[slot];
    end
  end

  // ####################
  // Read register.
  // ####################

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rdValidIn;
    end
  end

  // Side-band rides along with the data.
  always_ff @(posedge clk) begin
    if (rdValidIn) begin
      rdData    <= rdWord;
      isTableOp <= isTableOpIn;
      flipSign  <= flipSignIn;
      fracMask  <= fracMaskIn;
      fracField <= fracFieldIn;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/estIndexGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpEstTable_macros.svh"

module estIndexGen (
  input  wire logic                    clk,
  input  wire logic                    arstN,
  input  wire fpEstTable_pkg::fpWord   opA,
  input  wire fpEstTable_pkg::estOp    op,
  input  wire logic                    readEn,
  output fpEstTable_pkg::tableIdx      slot,
  output logic [5:0]                   fracMask,
  output logic                         isTableOp,
  output logic                         flipSign,
  output logic [5:0]                   fracField,
  output logic                         rdValid
);

  localparam logic [11:0] baseLo = 12'd2040;
  localparam logic [11:0] baseHi = 12'd2044;
  localparam int          flipBit = 64;

  logic [11:0] expo;
  logic [4:0]  m5;
  logic [2:0]  kLo;
  logic [2:0]  kHi;
  logic [5:0]  bucket;
  logic [5:0]  nextMask;
  logic        nextTableOp;
  logic        nextFlip;
  fpEstTable_pkg::tableIdx nextSlot;

  // ####################
  // Decoders.
  // ####################

  // Distance above base, 0 when outside 1..6.
  function automatic logic [2:0] stepsAbove(input logic [11:0] e, input logic [11:0] base);
    logic [11:0] d;
    d = e - base;
    return (d >= 12'd1 && d <= 12'd6) ? d[2:0] : 3'd0;
  endfunction

  // Leading one, then the top k-1 mantissa bits.
  function automatic logic [5:0] recipCode(input logic [2:0] k, input logic [4:0] m);
    if (k == 3'd0) begin
      return 6'd0;
    end
    return {1'b1, 5'(m >> (3'd6 - k))};
  endfunction

  // Exponent parity on top; the mantissa part starts at k of 2.
  function automatic logic [5:0] rsqrtCode(input logic [2:0] k, input logic e0,
                                           input logic [4:0] m);
    if (k == 3'd0) begin
      return 6'd0;
    end else if (k == 3'd1) begin
      return {e0, 5'd0};
    end
    return {e0, 1'b1, 4'(m >> (3'd7 - k))};
  endfunction

  // Low k bits set.
  function automatic logic [5:0] kMask(input logic [2:0] k);
    if (k == 3'd0) begin
      return 6'd0;
    end
    return 6'b111111 >> (3'd6 - k);
  endfunction

  assign expo = opA[`FPE_EXP_LSB +: 12];
  assign m5   = opA[`FPE_EXP_LSB-1 -: 5];
  assign kLo  = stepsAbove(expo, baseLo);
  assign kHi  = stepsAbove(expo, baseHi);

  always_comb begin
    case (op)
      fpEstTable_pkg::opRecip: bucket = recipCode(kLo, m5);
      fpEstTable_pkg::opRsqrt: bucket = rsqrtCode(kLo, expo[0], m5);
      default:                 bucket = recipCode(kHi, m5);
    endcase

    case (op)
      fpEstTable_pkg::opFracSh1: nextMask = kMask(kLo) << 1;
      fpEstTable_pkg::opFracSh2: nextMask = kMask(kLo) << 2;
      fpEstTable_pkg::opFracHi:  nextMask = kMask(kHi) << 1;
      default:                   nextMask = 6'd0;
    endcase
  end

  // Bucket times four stays below 256, so the sum packs as a concatenation.
  assign nextSlot    = {op[2], bucket, op[1:0] & {2{~op[2]}}};
  assign nextTableOp = op <= fpEstTable_pkg::opExpStep;
  assign nextFlip    = opA[flipBit] &&
                       (op == fpEstTable_pkg::opRecip || op == fpEstTable_pkg::opRecipHi);

  // ####################
  // Stage register.
  // ####################

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= readEn;
    end
  end

  always_ff @(posedge clk) begin
    if (readEn) begin
      slot      <= nextSlot;
      fracMask  <= nextMask;
      isTableOp <= nextTableOp;
      flipSign  <= nextFlip;
      fracField <= opA[52:47];  // Fraction bits under the mask.
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpEstTable_pkg.sv ====
`default_nettype none

`include "fpEstTable_macros.svh"

package fpEstTable_pkg;

  // ####################
  // Data words.
  // ####################

  // Operand, table entry and result.
  typedef logic [`FPE_WORD_W-1:0] fpWord;

  // Table slot number.
  typedef logic [`FPE_ADDR_W-1:0] tableIdx;

  // ####################
  // Operations.
  // ####################

  // 0 to 4 read the table, 5 to 7 return a masked fraction.
  typedef enum logic [2:0] {
    opRecip   = 3'd0,  // Reciprocal seed.
    opRsqrt   = 3'd1,  // Reciprocal square root seed.
    opRecipHi = 3'd2,
    opRsqrtHi = 3'd3,
    opExpStep = 3'd4,  // Upper table region.
    opFracSh1 = 3'd5,
    opFracSh2 = 3'd6,
    opFracHi  = 3'd7
  } estOp;

endpackage

`default_nettype wire

// ==== rtl/fpEstTable_macros.svh ====
`ifndef FPE_TABLE_MACROS_SVH
`define FPE_TABLE_MACROS_SVH

// ####################
// Word layout.
// ####################
`define FPE_WORD_W      68  // Tag, exponent and mantissa.
`define FPE_EXP_LSB     54  // Exponent sits at 65:54.

// ####################
// Table geometry.
// ####################
`define FPE_TABLE_DEPTH 320
`define FPE_ADDR_W      9
`define FPE_WADDR_LSB   45  // Write address is opB 53:45.

// Index, read and merge stages.
`define FPE_LATENCY     3

`endif
